/* compile.f */
+incdir+sim
rtl/hsid_cfg_pkg.sv
rtl/hsid_pkg.sv
rtl/hsid_measure_buf.sv
rtl/hsid_ref_fifo.sv
rtl/hsid_fsm.sv
rtl/hsid_mse.sv
rtl/hsid_compare.sv
rtl/hsid_top.sv
sim/hsid_tb.sv

/* rtl/hsid_cfg_pkg.sv */
package hsid_cfg_pkg;

  // Spectrum geometry
  localparam int HSI_BANDS = 16;                         // Bands per spectrum
  localparam int BAND_W = 8;                             // Bits per band sample
  localparam int WORD_W = 2 * BAND_W;                    // Two bands per word
  localparam int ELEMENTS = HSI_BANDS / 2;               // Words per vector
  localparam int ELEMENTS_ADDR = $clog2(ELEMENTS);       // Element counter width

  // Library limits
  localparam int HSI_LIBRARY_SIZE = 16;
  localparam int HSI_LIBRARY_SIZE_ADDR = $clog2(HSI_LIBRARY_SIZE);  // Vector index width

  // 16 bands of 255^2 fit easily in 24 bits
  localparam int SSE_W = 24;

  localparam int REF_FIFO_DEPTH = 4;                     // Power of two

endpackage

/* rtl/hsid_compare.sv */
`timescale 1ns/1ps

module hsid_compare
  import hsid_cfg_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             msi_valid,
  input  logic [SSE_W-1:0]                 msi_score,
  input  logic                             msi_last,
  output logic [HSI_LIBRARY_SIZE_ADDR-1:0] best_index,
  output logic [SSE_W-1:0]                 best_mse,
  output logic                             msi_comparison_valid
);

  logic [HSI_LIBRARY_SIZE_ADDR-1:0] idx_count;  // Index of the incoming score
  logic                             take;

  // First vector of a run always wins and ties keep the lower index
  assign take = msi_valid && ((idx_count == '0) || (msi_score < best_mse));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_count            <= '0;
      best_index           <= '0;
      best_mse             <= '0;
      msi_comparison_valid <= 1'b0;
    end else begin
      msi_comparison_valid <= msi_valid && msi_last;  // Run result settled
      if (msi_valid) begin
        idx_count <= msi_last ? '0 : idx_count + 1'b1;
      end
      if (take) begin
        best_index <= idx_count;
        best_mse   <= msi_score;
      end
    end
  end

endmodule

/* rtl/hsid_fsm.sv */
`timescale 1ns/1ps

module hsid_fsm
  import hsid_cfg_pkg::*, hsid_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  logic [HSI_LIBRARY_SIZE_ADDR:0] hsi_library_size,
  input  logic                           fifo_measure_full,
  input  logic                           fifo_measure_empty,
  input  logic                           fifo_ref_full,
  input  logic                           fifo_ref_empty,
  input  logic                           msi_valid,
  input  logic                           msi_comparison_valid,
  output hsid_state_t                    state,
  output logic                           fifo_both_read_en,
  output logic                           element_start,
  output logic                           element_last,
  output logic                           element_valid,
  output logic                           vctr_last,
  output logic                           idle,
  output logic                           ready,
  output logic                           done
);

  localparam logic [ELEMENTS_ADDR-1:0] LAST_ELEM = ELEMENTS_ADDR'(ELEMENTS - 1);

  hsid_state_t                      next_state;
  logic [ELEMENTS_ADDR-1:0]         element_count;
  logic [HSI_LIBRARY_SIZE_ADDR-1:0] vctr_count;  // Vectors fully read
  logic                             cnt_clear;
  logic                             rd_last_elem;  // Reading last word of a vector

  assign fifo_both_read_en = (state == COMPUTE_MSE) && !fifo_ref_empty && !fifo_measure_empty;
  assign rd_last_elem = fifo_both_read_en && (element_count == LAST_ELEM);
  assign cnt_clear = (state == IDLE) && start;
  // Counter moves one cycle after the read, so this holds through element_last
  assign vctr_last = ({1'b0, vctr_count} == hsi_library_size - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= IDLE;
      element_count <= '0;
      vctr_count    <= '0;
      element_valid <= 1'b0;
      element_start <= 1'b0;
      element_last  <= 1'b0;
    end else begin
      state <= next_state;
      // Strobes line up with the registered read data
      element_valid <= fifo_both_read_en;
      element_start <= fifo_both_read_en && (element_count == '0);
      element_last  <= rd_last_elem;
      if (cnt_clear) begin
        element_count <= '0;
        vctr_count    <= '0;
      end else begin
        if (fifo_both_read_en) begin
          element_count <= rd_last_elem ? '0 : element_count + 1'b1;
        end
        if (element_valid && element_last) begin
          vctr_count <= vctr_count + 1'b1;
        end
      end
    end
  end

  always_comb begin
    next_state = state;
    idle  = 1'b0;
    ready = 1'b0;
    done  = 1'b0;
    case (state)
      IDLE: begin
        idle = 1'b1;
        if (start) next_state = READ_MEASURE;
      end
      READ_MEASURE: begin
        ready = 1'b1;  // Host loads the pixel
        if (fifo_measure_full) next_state = COMPUTE_MSE;
      end
      COMPUTE_MSE: begin
        ready = !fifo_ref_full;  // Back-pressure on the library stream
        if (rd_last_elem && vctr_last) next_state = WAIT_MSE;
      end
      WAIT_MSE: begin
        if (msi_valid) next_state = COMPARE_MSE;
      end
      COMPARE_MSE: begin
        if (msi_comparison_valid) next_state = DONE;
      end
      DONE: begin
        done       = 1'b1;
        next_state = IDLE;
      end
      default: begin
        idle       = 1'b1;
        next_state = IDLE;
      end
    endcase
  end

endmodule

/* rtl/hsid_measure_buf.sv */
`timescale 1ns/1ps

module hsid_measure_buf
  import hsid_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [WORD_W-1:0] measure_data,
  input  logic              measure_valid,
  input  logic              clear,
  input  logic              read_en,
  output logic [WORD_W-1:0] rd_data,
  output logic              full,
  output logic              empty
);

  logic [WORD_W-1:0]        mem [ELEMENTS];  // Pixel vector storage
  logic [ELEMENTS_ADDR-1:0] wr_ptr;
  logic [ELEMENTS_ADDR-1:0] rd_ptr;           // Wraps to replay the vector
  logic                     loaded;           // All words present

  localparam logic [ELEMENTS_ADDR-1:0] LAST_PTR = ELEMENTS_ADDR'(ELEMENTS - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      loaded <= 1'b0;
    end else if (clear) begin  // End of run
      wr_ptr <= '0;
      rd_ptr <= '0;
      loaded <= 1'b0;
    end else begin
      if (measure_valid && !loaded) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
        loaded <= (wr_ptr == LAST_PTR);  // Last word completes the vector
      end
      if (read_en) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Pixel words and the replay register
  always_ff @(posedge clk) begin
    if (measure_valid && !loaded) begin
      mem[wr_ptr] <= measure_data;
    end
    if (read_en) begin
      rd_data <= mem[rd_ptr];  // Registered replay word
    end
  end

  assign full  = loaded;
  assign empty = !loaded && (wr_ptr == '0);  // Nothing written yet

endmodule

/* rtl/hsid_mse.sv */
`timescale 1ns/1ps

module hsid_mse
  import hsid_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [WORD_W-1:0] measure_word,
  input  logic [WORD_W-1:0] ref_word,
  input  logic              element_valid,
  input  logic              element_start,
  input  logic              element_last,
  input  logic              vctr_last,
  output logic              msi_valid,
  output logic [SSE_W-1:0]  msi_score,
  output logic              msi_last
);

  logic [BAND_W-1:0]   d_lo, d_hi;     // Absolute band differences
  logic [2*BAND_W-1:0] sq_lo, sq_hi;
  logic [2*BAND_W:0]   sq_sum;         // One carry bit
  logic [2*BAND_W:0]   s1_sum;
  logic                s1_valid, s1_start, s1_last, s1_vlast;
  logic [SSE_W-1:0]    acc;

  // Even band in the low byte
  assign d_lo = (measure_word[BAND_W-1:0] > ref_word[BAND_W-1:0]) ?
                measure_word[BAND_W-1:0] - ref_word[BAND_W-1:0] :
                ref_word[BAND_W-1:0] - measure_word[BAND_W-1:0];
  assign d_hi = (measure_word[WORD_W-1:BAND_W] > ref_word[WORD_W-1:BAND_W]) ?
                measure_word[WORD_W-1:BAND_W] - ref_word[WORD_W-1:BAND_W] :
                ref_word[WORD_W-1:BAND_W] - measure_word[WORD_W-1:BAND_W];
  assign sq_lo  = d_lo * d_lo;
  assign sq_hi  = d_hi * d_hi;
  assign sq_sum = sq_lo + sq_hi;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_start  <= 1'b0;
      s1_last   <= 1'b0;
      s1_vlast  <= 1'b0;
      msi_valid <= 1'b0;
      msi_last  <= 1'b0;
    end else begin
      s1_valid  <= element_valid;              // Stage one strobes
      s1_start  <= element_valid && element_start;
      s1_last   <= element_valid && element_last;
      s1_vlast  <= vctr_last;                  // Sampled with the word
      msi_valid <= s1_valid && s1_last;        // Vector total ready
      if (s1_valid && s1_last) msi_last <= s1_vlast;
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    s1_sum <= sq_sum;
    if (s1_valid) begin
      // Restart on the first word of each vector
      acc <= s1_start ? {{(SSE_W-2*BAND_W-1){1'b0}}, s1_sum}
                      : acc + {{(SSE_W-2*BAND_W-1){1'b0}}, s1_sum};
    end
  end

  assign msi_score = acc;  // Held until the next vector starts

endmodule

/* rtl/hsid_pkg.sv */
package hsid_pkg;

  // Run states of the control FSM
  typedef enum logic [2:0] {
    IDLE,           // Waiting for start
    READ_MEASURE,   // Loading the pixel vector
    COMPUTE_MSE,    // Streaming the library
    WAIT_MSE,       // Last score still in the pipeline
    COMPARE_MSE,    // Last score in the comparator
    DONE            // One-cycle done pulse
  } hsid_state_t;

endpackage

/* rtl/hsid_ref_fifo.sv */
`timescale 1ns/1ps

module hsid_ref_fifo
  import hsid_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [WORD_W-1:0] wr_data,
  input  logic              wr_en,
  input  logic              rd_en,
  output logic [WORD_W-1:0] rd_data,
  output logic              full,
  output logic              empty
);

  logic [WORD_W-1:0]                     mem [REF_FIFO_DEPTH];
  logic [$clog2(REF_FIFO_DEPTH)-1:0]     wr_ptr;  // Natural wrap
  logic [$clog2(REF_FIFO_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(REF_FIFO_DEPTH):0]       count;   // Occupancy
  logic                                  wr_ok;
  logic                                  rd_ok;

  assign wr_ok = wr_en && !full;   // Writes into a full FIFO are lost
  assign rd_ok = rd_en && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_ptr] <= wr_data;
    if (rd_ok) rd_data <= mem[rd_ptr];  // One cycle after rd_en
  end

  assign full  = (count == REF_FIFO_DEPTH);
  assign empty = (count == '0);

endmodule

/* rtl/hsid_top.sv */
`timescale 1ns/1ps

module hsid_top
  import hsid_cfg_pkg::*, hsid_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [HSI_LIBRARY_SIZE_ADDR:0]   hsi_library_size,
  input  logic [WORD_W-1:0]                measure_data,
  input  logic                             measure_valid,
  input  logic [WORD_W-1:0]                ref_data,
  input  logic                             ref_valid,
  output logic                             idle,
  output logic                             ready,
  output logic                             done,
  output logic [HSI_LIBRARY_SIZE_ADDR-1:0] best_index,
  output logic [SSE_W-1:0]                 best_mse
);

  logic [WORD_W-1:0] meas_word, ref_word;
  logic              meas_full, meas_empty, ref_full, ref_empty;
  logic              both_rd_en;
  logic              element_start, element_last, element_valid, vctr_last;
  logic              msi_valid, msi_last, msi_comparison_valid;
  logic [SSE_W-1:0]  msi_score;

  hsid_measure_buf measure_buf_i (
    .clk, .rst_n, .measure_data, .measure_valid,
    .clear   (done),        // Emptied at the end of every run
    .read_en (both_rd_en),
    .rd_data (meas_word),
    .full    (meas_full),
    .empty   (meas_empty)
  );

  hsid_ref_fifo ref_fifo_i (
    .clk, .rst_n,
    .wr_data (ref_data),
    .wr_en   (ref_valid),
    .rd_en   (both_rd_en),
    .rd_data (ref_word),
    .full    (ref_full),
    .empty   (ref_empty)
  );

  hsid_fsm fsm_i (
    .clk, .rst_n, .start, .hsi_library_size,
    .fifo_measure_full (meas_full),
    .fifo_measure_empty(meas_empty),
    .fifo_ref_full     (ref_full),
    .fifo_ref_empty    (ref_empty),
    .msi_valid, .msi_comparison_valid,
    .state             (),
    .fifo_both_read_en (both_rd_en),
    .element_start, .element_last, .element_valid, .vctr_last,
    .idle, .ready, .done
  );

  hsid_mse mse_i (
    .clk, .rst_n,
    .measure_word (meas_word),
    .ref_word     (ref_word),
    .element_valid, .element_start, .element_last, .vctr_last,
    .msi_valid, .msi_score, .msi_last
  );

  hsid_compare compare_i (
    .clk, .rst_n, .msi_valid, .msi_score, .msi_last,
    .best_index, .best_mse, .msi_comparison_valid
  );

endmodule

/* sim/hsid_tb_tasks.svh */
// Bytes of 0 or 255 when extreme is set
function automatic logic [WORD_W-1:0] random_word(input bit extreme);
  logic [31:0] r;
  r = lcg_next();
  if (extreme) return {{BAND_W{r[20]}}, {BAND_W{r[9]}}};
  return r[31:16];
endfunction

function automatic void fill_vectors(input int n, input bit extreme);
  foreach (meas[e]) meas[e] = random_word(extreme);
  for (int v = 0; v < n; v++) begin
    foreach (meas[e]) lib[v][e] = random_word(extreme);
  end
endfunction

// One word per strobe while ready is high
task automatic send_word(input bit to_ref, input logic [WORD_W-1:0] w);
  int t;
  t = 0;
  while (!ready) begin
    @(negedge clk);
    t++;
    if (t > TIMEOUT) report_timeout("ready stayed low");
  end
  if (to_ref) begin
    ref_data  = w;
    ref_valid = 1'b1;
  end else begin
    measure_data  = w;
    measure_valid = 1'b1;
  end
  @(negedge clk);
  ref_valid     = 1'b0;
  measure_valid = 1'b0;
endtask

task automatic run_library(input int n, input int max_gap);
  int t;
  expect_result(n);
  t = 0;
  while (!idle) begin
    @(negedge clk);
    t++;
    if (t > TIMEOUT) report_timeout("idle never rose before start");
  end
  hsi_library_size = (HSI_LIBRARY_SIZE_ADDR+1)'(n);  // Held until done
  start = 1'b1;
  @(negedge clk);
  start = 1'b0;
  foreach (meas[e]) send_word(1'b0, meas[e]);
  for (int v = 0; v < n; v++) begin
    foreach (meas[e]) begin
      if (max_gap > 0) repeat ((lcg_next() >> 16) % (max_gap + 1)) @(negedge clk);
      send_word(1'b1, lib[v][e]);
    end
  end
  t = 0;
  while (!done) begin
    @(negedge clk);
    t++;
    if (t > TIMEOUT) report_timeout("done never pulsed");
  end
  @(negedge clk);  // Past the done cycle
endtask

/* sim/hsid_tb.sv */
`timescale 1ns/1ps

module hsid_tb
  import hsid_cfg_pkg::*;
();

  localparam int TIMEOUT = 2000;  // Cycles allowed per wait

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             start;
  logic [HSI_LIBRARY_SIZE_ADDR:0]   hsi_library_size;
  logic [WORD_W-1:0]                measure_data;
  logic [WORD_W-1:0]                ref_data;
  logic                             measure_valid;
  logic                             ref_valid;
  logic                             idle;
  logic                             ready;
  logic                             done;
  logic [HSI_LIBRARY_SIZE_ADDR-1:0] best_index;
  logic [SSE_W-1:0]                 best_mse;

  logic [31:0]       seed = 32'h6088e673;
  logic [WORD_W-1:0] meas [ELEMENTS];                    // Pixel vector
  logic [WORD_W-1:0] lib  [HSI_LIBRARY_SIZE][ELEMENTS];  // Library vectors
  int                exp_index;
  int                exp_mse;
  int                errors = 0;
  int                timeouts = 0;
  logic              prev_done = 1'b0;

  hsid_top dut_i (.*);

  always #50 clk = ~clk;  // 100 ns period

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Sum of squared band differences without division
  function automatic int vector_score(input int v);
    int s;
    int d;
    s = 0;
    for (int e = 0; e < ELEMENTS; e++) begin
      for (int b = 0; b < 2; b++) begin
        d = int'(meas[e][BAND_W*b +: BAND_W]) - int'(lib[v][e][BAND_W*b +: BAND_W]);
        s += d * d;
      end
    end
    return s;
  endfunction

  function automatic void expect_result(input int n);
    int s;
    exp_index = 0;
    exp_mse   = vector_score(0);
    for (int v = 1; v < n; v++) begin
      s = vector_score(v);
      if (s < exp_mse) begin  // Strictly lower, ties keep the earlier index
        exp_index = v;
        exp_mse   = s;
      end
    end
  endfunction

  function automatic void check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      errors++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endfunction

  task automatic finish_run();
    $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
    finish_run();
  endtask

  `include "hsid_tb_tasks.svh"

  // Result check on every done pulse
  always @(negedge clk) begin
    if (done) begin
      check_value("best_index", best_index, exp_index);
      check_value("best_mse", best_mse, exp_mse);
      assert (!prev_done) else begin
        errors++;
        $display("done stayed high for more than one cycle at %0t", $time);
      end
    end
    prev_done <= done;
  end

  initial begin
    rst_n            = 1'b0;
    start            = 1'b0;
    hsi_library_size = '0;
    measure_data     = '0;
    measure_valid    = 1'b0;
    ref_data         = '0;
    ref_valid        = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("idle", idle, 1);  // Status after reset
    check_value("ready", ready, 0);
    check_value("done", done, 0);
    fill_vectors(HSI_LIBRARY_SIZE, 1'b0);
    run_library(HSI_LIBRARY_SIZE, 0);
    fill_vectors(1, 1'b0);
    run_library(1, 0);
    fill_vectors(5, 1'b0);  // New pixel needs a cleared buffer
    run_library(5, 0);
    fill_vectors(8, 1'b0);
    lib[2] = meas;  // Two exact matches where the lower index wins
    lib[6] = meas;
    run_library(8, 0);
    fill_vectors(HSI_LIBRARY_SIZE, 1'b0);
    run_library(HSI_LIBRARY_SIZE, 3);  // Bursts with gaps
    fill_vectors(3, 1'b1);
    foreach (meas[e]) lib[0][e] = ~meas[e];  // Largest possible score
    run_library(3, 1);
    run_library(1, 0);  // Largest score comes back whole
    finish_run();
  end

endmodule
